//--- memc_intf.f
hdl/memc_pkg.sv
hdl/memc_ctrl_fsm.sv
hdl/memc_addr_tracker.sv
hdl/memc_wr_packer.sv
hdl/memc_intf.sv
tests/memc_intf_tb.sv

//--- Bender.yml
package:
  name: memc_intf

sources:
  - hdl/memc_pkg.sv
  - hdl/memc_ctrl_fsm.sv
  - hdl/memc_addr_tracker.sv
  - hdl/memc_wr_packer.sv
  - hdl/memc_intf.sv
  - target: test
    files:
      - tests/memc_intf_tb.sv

//--- tests/memc_intf_tb.sv
/* random-stimulus testbench for the DDR front end; models the line buffer and the
   controller's command acceptance, and scores commands, write beats and row markers */
`timescale 1ns/1ps

module memc_intf_tb;

  localparam int ROW_NUM = 4;
  localparam int CLK_PERIOD = 8;
  localparam int RST_CYCLES = 4;
  localparam int CALIB_WAIT = 20;
  // row pairs written over the run
  localparam int NUM_ROW_PAIRS = 20;
  // cycles allowed per row pair
  localparam int CYC_PER_ROW = 400;
  // two row pairs per image at ROW_NUM 4
  localparam int CMDS_PER_IMG = (ROW_NUM / 2) * memc_pkg::CMDS_PER_ROW;
  localparam int IMG_STRIDE = ROW_NUM * 20;
  localparam int TOTAL_CMDS = NUM_ROW_PAIRS * memc_pkg::CMDS_PER_ROW;
  localparam int BUF_DEPTH = 1 << memc_pkg::BUF_ADDR_WIDTH;
  localparam int DW = memc_pkg::DATA_WIDTH;

  logic clk = 1'b0;
  logic rst;
  logic init_calib_complete;
  logic pkt_ready;
  logic [7:0] rx_buf_data;
  logic app_rdy;
  logic post_ddr_ram_full;
  logic [memc_pkg::BUF_ADDR_WIDTH-1:0] rd_addr_buf;
  logic wr_row_done;
  memc_pkg::ddr_cmd_t ddr_cmd;
  memc_pkg::ddr_wdf_t ddr_wdf;

  // model state
  logic [31:0] seed;
  logic [memc_pkg::BUF_ADDR_WIDTH-1:0] buf_addr_q;
  logic wr_acc;
  logic rd_acc;
  logic acc_d1;
  logic acc_d2;
  logic row_evt_d1;
  logic finished;
  int cyc;
  int wr_cnt;
  int rd_cnt;
  int beat_cnt;
  int model_frames;
  int rows_started;
  int rows_done;
  int full_run;
  int full_left;
  int value_errs;
  int proto_errs;

  memc_intf #(.ROW_NUM(ROW_NUM)) dut0 (
    .clk                 (clk),
    .rst                 (rst),
    .init_calib_complete (init_calib_complete),
    .pkt_ready           (pkt_ready),
    .rx_buf_data         (rx_buf_data),
    .app_rdy             (app_rdy),
    .post_ddr_ram_full   (post_ddr_ram_full),
    .rd_addr_buf         (rd_addr_buf),
    .wr_row_done         (wr_row_done),
    .ddr_cmd             (ddr_cmd),
    .ddr_wdf             (ddr_wdf)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // ********************
  // helpers
  // ********************
  // lcg step returning the better mixed upper half
  function automatic logic [15:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed[31:16];
  endfunction

  // line buffer byte as a hash of the whole address
  function automatic logic [7:0] buf_byte(input logic [memc_pkg::BUF_ADDR_WIDTH-1:0] a);
    return (a[7:0] * 8'd151) ^ {a[10:8], a[4:0]} ^ 8'h3c;
  endfunction

  // k-th burst with its first byte in the top bits
  function automatic logic [DW-1:0] burst_bytes(input int k);
    logic [DW-1:0] r;
    int a;
    r = '0;
    for (int i = 0; i < memc_pkg::DATA_BYTES; i++)
    begin
      a = (k * memc_pkg::DATA_BYTES + i) % BUF_DEPTH;
      r = {r[DW-9:0], buf_byte(a[memc_pkg::BUF_ADDR_WIDTH-1:0])};
    end
    return r;
  endfunction

  // address of the n-th command in one direction
  function automatic logic [memc_pkg::ADDR_WIDTH-1:0] expect_addr(input int n);
    logic [memc_pkg::ADDR_WIDTH-1:0] r;
    r = (n / CMDS_PER_IMG) * IMG_STRIDE + (n % CMDS_PER_IMG) * memc_pkg::ADDR_STEP;
    return r;
  endfunction

  task automatic compare_value(input string name, input logic [DW-1:0] exp,
                               input logic [DW-1:0] act);
    assert (exp === act)
    else
    begin
      value_errs++;
      $display("ERR %s expected %0h actual %0h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic check_rule(input logic cond, input string msg);
    assert (cond)
    else
    begin
      proto_errs++;
      $display("%s at %0t", msg, $time);
    end
  endtask

  task automatic print_summary();
    $display("errors: %0d value, %0d protocol", value_errs, proto_errs);
  endtask

  // ********************
  // drive and score
  // ********************
  always @(negedge clk)
  begin
    // reset and calibration by cycle count
    cyc++;
    rst = (cyc < RST_CYCLES);
    init_calib_complete = (cyc >= RST_CYCLES + CALIB_WAIT);
    // controller ready about 70% of cycles
    app_rdy = (next_rand() % 10) < 7;
    // occasional full bursts from the read side
    if (full_left > 0)
    begin
      post_ddr_ram_full = 1'b1;
      full_left--;
    end
    else
    begin
      post_ddr_ram_full = 1'b0;
      if (next_rand() % 40 == 0)
        full_left = 3 + next_rand() % 8;
    end
    // a row pair is pending until its marker
    if (wr_row_done)
      pkt_ready = 1'b0;
    else if (!pkt_ready && rows_started < NUM_ROW_PAIRS && next_rand() % 4 == 0)
    begin
      pkt_ready = 1'b1;
      rows_started++;
    end
    // sync read returns the byte one cycle after its address
    rx_buf_data = buf_byte(buf_addr_q);
    buf_addr_q = rd_addr_buf;

    // sample what the next rising edge will see
    #(CLK_PERIOD / 4);
    if (!rst)
    begin
      full_run = post_ddr_ram_full ? full_run + 1 : 0;
      wr_acc = ddr_cmd.en && app_rdy && (ddr_cmd.cmd == memc_pkg::CMD_WRITE);
      rd_acc = ddr_cmd.en && app_rdy && (ddr_cmd.cmd == memc_pkg::CMD_READ);
      // controller stays quiet until calibrated
      if (!init_calib_complete)
        compare_value("pre_calib", '0,
                      {ddr_cmd.en, ddr_wdf.wren, ddr_wdf.last, wr_row_done});
      check_rule(!ddr_cmd.en || app_rdy,
                 "command enable raised while the controller was not ready");
      check_rule(!(ddr_cmd.en && app_rdy) || wr_acc || rd_acc,
                 "accepted command carries an unknown code");
      // marker one cycle and beat two cycles after the write accept
      compare_value("wr_row_done", row_evt_d1, wr_row_done);
      compare_value("wdf_wren", acc_d2, ddr_wdf.wren);
      compare_value("wdf_last", acc_d2, ddr_wdf.last);
      if (ddr_wdf.wren)
      begin
        compare_value("beat_data", burst_bytes(beat_cnt), ddr_wdf.data);
        beat_cnt++;
      end
      if (wr_acc)
      begin
        check_rule(pkt_ready, "write command accepted with no row pending");
        compare_value("wr_addr", expect_addr(wr_cnt), ddr_cmd.addr);
        // whole burst fetched and the address held since
        compare_value("buf_addr", ((wr_cnt + 1) * memc_pkg::DATA_BYTES) % BUF_DEPTH,
                      rd_addr_buf);
        wr_cnt++;
        if (wr_cnt % CMDS_PER_IMG == 0)
          model_frames++;
      end
      if (rd_acc)
      begin
        check_rule(model_frames != 0, "read accepted with no complete image in memory");
        check_rule(rd_cnt < CMDS_PER_IMG * (wr_cnt / CMDS_PER_IMG),
                   "more reads than written images hold");
        check_rule(full_run < 3, "read accepted while the full flag was held");
        compare_value("rd_addr", expect_addr(rd_cnt), ddr_cmd.addr);
        rd_cnt++;
        if (rd_cnt % CMDS_PER_IMG == 0)
          model_frames--;
      end
      if (wr_row_done)
        rows_done++;
      row_evt_d1 = wr_acc && (wr_cnt % memc_pkg::CMDS_PER_ROW == 0);
      acc_d2 = acc_d1;
      acc_d1 = wr_acc;
      finished = (rows_done == NUM_ROW_PAIRS) && (rd_cnt == TOTAL_CMDS) &&
                 (beat_cnt == wr_cnt);
    end
  end

  // ********************
  // run control
  // ********************
  initial
  begin
    rst = 1'b1;
    init_calib_complete = 1'b0;
    pkt_ready = 1'b0;
    rx_buf_data = 8'h00;
    app_rdy = 1'b0;
    post_ddr_ram_full = 1'b0;
    seed = 32'h7a39;
    buf_addr_q = '0;
    acc_d1 = 1'b0;
    acc_d2 = 1'b0;
    row_evt_d1 = 1'b0;
    finished = 1'b0;
    cyc = 0;
    wr_cnt = 0;
    rd_cnt = 0;
    beat_cnt = 0;
    model_frames = 0;
    rows_started = 0;
    rows_done = 0;
    full_run = 0;
    full_left = 0;
    value_errs = 0;
    proto_errs = 0;
    wait (finished);
    // a few idle cycles catch stray commands
    repeat (4) @(negedge clk);
    compare_value("wr_total", TOTAL_CMDS, wr_cnt);
    compare_value("beat_total", wr_cnt, beat_cnt);
    print_summary();
    if (value_errs + proto_errs == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

  // watchdog sized from the row count
  initial
  begin
    #((RST_CYCLES + CALIB_WAIT + NUM_ROW_PAIRS * CYC_PER_ROW) * CLK_PERIOD);
    $display("watchdog expired with %0d row pairs written and %0d reads", rows_done, rd_cnt);
    print_summary();
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

//--- hdl/memc_intf.sv
/* DDR front end top: writes line-buffer rows into DDR and reads whole images
   back over the native application port of a calibrated controller */
`timescale 1ns/1ps

module memc_intf
#(
  // image lines
  parameter int ROW_NUM = 720
)
(
  input  logic clk,
  input  logic rst,
  input  logic init_calib_complete,
  input  logic pkt_ready,
  input  logic [7:0] rx_buf_data,
  input  logic app_rdy,
  input  logic post_ddr_ram_full,
  output logic [memc_pkg::BUF_ADDR_WIDTH-1:0] rd_addr_buf,
  output logic wr_row_done,
  output memc_pkg::ddr_cmd_t ddr_cmd,
  output memc_pkg::ddr_wdf_t ddr_wdf
);

  memc_pkg::memc_state_e state;
  memc_pkg::track_t wr_track;
  memc_pkg::track_t rd_track;
  logic wr_accept;
  logic rd_accept;
  logic fill_en;
  logic cmd_en;
  logic burst_ready;
  logic [2:0] cmd_code;
  logic [memc_pkg::ADDR_WIDTH-1:0] cmd_addr;

  // ********************
  // control
  // ********************
  memc_ctrl_fsm u_ctrl (
    .clk                 (clk),
    .rst                 (rst),
    .init_calib_complete (init_calib_complete),
    .pkt_ready           (pkt_ready),
    .app_rdy             (app_rdy),
    .post_ddr_ram_full   (post_ddr_ram_full),
    .burst_ready         (burst_ready),
    .wr_track            (wr_track),
    .rd_track            (rd_track),
    .state               (state),
    .wr_accept           (wr_accept),
    .rd_accept           (rd_accept),
    .fill_en             (fill_en),
    .cmd_en              (cmd_en),
    .cmd_code            (cmd_code)
  );

  // ********************
  // address trackers
  // ********************
  memc_addr_tracker #(.ROW_NUM(ROW_NUM)) u_wr_track (
    .clk    (clk),
    .rst    (rst),
    .accept (wr_accept),
    .track  (wr_track)
  );

  memc_addr_tracker #(.ROW_NUM(ROW_NUM)) u_rd_track (
    .clk    (clk),
    .rst    (rst),
    .accept (rd_accept),
    .track  (rd_track)
  );

  // write data path
  memc_wr_packer u_packer (
    .clk         (clk),
    .rst         (rst),
    .fill_en     (fill_en),
    .wr_accept   (wr_accept),
    .rx_buf_data (rx_buf_data),
    .burst_ready (burst_ready),
    .rd_addr_buf (rd_addr_buf),
    .wdf         (ddr_wdf)
  );

  // read address only in rd_data
  assign cmd_addr = (state == memc_pkg::rd_data) ? rd_track.addr : wr_track.addr;
  assign ddr_cmd = '{en: cmd_en, cmd: cmd_code, addr: cmd_addr};

  // row pair fully handed to DDR
  assign wr_row_done = wr_track.row_done;

endmodule

//--- hdl/memc_wr_packer.sv
/* gathers line-buffer bytes into 64-byte bursts for DDR writes and times
   the write data beat two cycles after each accepted write command */
`timescale 1ns/1ps

module memc_wr_packer
(
  input  logic clk,
  input  logic rst,
  input  logic fill_en,
  input  logic wr_accept,
  input  logic [7:0] rx_buf_data,
  output logic burst_ready,
  output logic [memc_pkg::BUF_ADDR_WIDTH-1:0] rd_addr_buf,
  output memc_pkg::ddr_wdf_t wdf
);

  localparam int DW = memc_pkg::DATA_WIDTH;
  // one extra bit so a full burst reads 64
  localparam int CNT_W = $clog2(memc_pkg::DATA_BYTES) + 1;

  logic [CNT_W-1:0] byte_cnt;
  logic fetch;
  logic fetch_vld;
  logic [DW-1:0] burst_data;
  logic beat_d1;
  logic beat_d2;

  // ********************
  // buffer fetch
  // ********************
  // full burst waits for its command
  assign burst_ready = (byte_cnt == CNT_W'(memc_pkg::DATA_BYTES));
  // no fetch on the accept cycle, the beat still reads this burst
  assign fetch = fill_en && !burst_ready;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      byte_cnt <= '0;
      rd_addr_buf <= '0;
      fetch_vld <= 1'b0;
    end
    else
    begin
      fetch_vld <= fetch;
      if (wr_accept)
        byte_cnt <= '0;
      else if (fetch)
        byte_cnt <= byte_cnt + 1'b1;
      // address runs on across rows and wraps
      if (fetch)
        rd_addr_buf <= rd_addr_buf + 1'b1;
    end
  end

  // ********************
  // 8 to 512 packing
  // ********************
  // byte lands a cycle after its address; oldest ends at the top
  always_ff @(posedge clk)
  begin
    if (fetch_vld)
      burst_data <= {burst_data[DW-9:0], rx_buf_data};
  end

  // beat two cycles after the accepted write command
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      beat_d1 <= 1'b0;
      beat_d2 <= 1'b0;
    end
    else
    begin
      beat_d1 <= wr_accept;
      beat_d2 <= beat_d1;
    end
  end

  // every beat is a whole burst, so last follows wren
  assign wdf = '{wren: beat_d2, last: beat_d2, data: burst_data};

endmodule

//--- hdl/memc_addr_tracker.sv
/* per-direction DDR address generator; counts accepted commands and row pairs
   and reports base plus offset with row and image markers */
`timescale 1ns/1ps

module memc_addr_tracker
#(
  parameter int ROW_NUM = 720
)
(
  input  logic clk,
  input  logic rst,
  input  logic accept,
  output memc_pkg::track_t track
);

  // two lines make one row pair
  localparam int ROW_PAIRS = ROW_NUM / 2;
  // address span of one image, ROW_NUM * 20 units
  localparam int IMG_STRIDE = (ROW_NUM * memc_pkg::CMDS_PER_ROW * memc_pkg::ADDR_STEP) / 2;
  localparam int CMD_W = $clog2(memc_pkg::CMDS_PER_ROW);
  localparam int ROW_W = $clog2(ROW_PAIRS + 1);
  localparam int AW = memc_pkg::ADDR_WIDTH;

  logic [CMD_W-1:0] cmd_cnt;
  logic [ROW_W-1:0] row_cnt;
  logic [AW-1:0] base;
  logic [AW-1:0] offset;
  logic row_end;
  logic img_end;
  logic row_done;
  logic image_done;

  // last command of a row pair / of an image
  assign row_end = accept && (cmd_cnt == CMD_W'(memc_pkg::CMDS_PER_ROW - 1));
  assign img_end = row_end && (row_cnt == ROW_W'(ROW_PAIRS - 1));

  // ********************
  // counters
  // ********************
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      cmd_cnt <= '0;
      row_cnt <= '0;
    end
    else if (accept)
    begin
      // commands modulo five
      if (row_end)
        cmd_cnt <= '0;
      else
        cmd_cnt <= cmd_cnt + 1'b1;
      // row pairs modulo ROW_NUM/2
      if (img_end)
        row_cnt <= '0;
      else if (row_end)
        row_cnt <= row_cnt + 1'b1;
    end
  end

  // ********************
  // address
  // ********************
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      base <= '0;
      offset <= '0;
    end
    else if (accept)
    begin
      if (img_end)
      begin
        // next image starts one stride on
        base <= base + AW'(IMG_STRIDE);
        offset <= '0;
      end
      else
        offset <= offset + AW'(memc_pkg::ADDR_STEP);
    end
  end

  // markers, one cycle after the event
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      row_done <= 1'b0;
      image_done <= 1'b0;
    end
    else
    begin
      row_done <= row_end;
      image_done <= img_end;
    end
  end

  assign track = '{addr: base + offset, row_end: row_end, row_done: row_done,
                   image_done: image_done};

endmodule

//--- hdl/memc_ctrl_fsm.sv
/* write-first arbiter for the DDR native port, with the full-flag synchronizer,
   the frame counter that gates reads, and the command enable and accept strobes */
`timescale 1ns/1ps

module memc_ctrl_fsm
(
  input  logic clk,
  input  logic rst,
  input  logic init_calib_complete,
  input  logic pkt_ready,
  input  logic app_rdy,
  input  logic post_ddr_ram_full,
  input  logic burst_ready,
  input  memc_pkg::track_t wr_track,
  input  memc_pkg::track_t rd_track,
  output memc_pkg::memc_state_e state,
  output logic wr_accept,
  output logic rd_accept,
  output logic fill_en,
  output logic cmd_en,
  output logic [2:0] cmd_code
);

  memc_pkg::memc_state_e next_state;
  logic full_meta;
  logic full_sync;
  logic [memc_pkg::FRAME_CNT_WIDTH-1:0] frame_cnt;

  // ********************
  // full flag crossing
  // ********************
  // flag comes from the image clock, two flops
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      full_meta <= 1'b0;
      full_sync <= 1'b0;
    end
    else
    begin
      full_meta <= post_ddr_ram_full;
      full_sync <= full_meta;
    end
  end

  // ********************
  // arbiter
  // ********************
  always_ff @(posedge clk)
  begin
    if (rst)
      state <= memc_pkg::idle;
    else
      state <= next_state;
  end

  always_comb
  begin
    next_state = state;
    case (state)
      memc_pkg::idle:
      begin
        // write first, then read if a full image waits
        if (init_calib_complete && pkt_ready)
          next_state = memc_pkg::wr_data;
        // skip while a read image_done is still to be counted
        else if (init_calib_complete && frame_cnt != '0 && !rd_track.image_done)
          next_state = memc_pkg::rd_data;
      end
      memc_pkg::wr_data:
      begin
        // one row pair per visit
        if (wr_track.row_done)
          next_state = memc_pkg::idle;
      end
      memc_pkg::rd_data:
      begin
        // leave on back-pressure or at the end of a row pair
        if (full_sync || rd_track.row_end)
          next_state = memc_pkg::idle;
      end
      default:
        next_state = memc_pkg::idle;
    endcase
  end

  // ********************
  // command strobes
  // ********************
  assign cmd_en = app_rdy &&
                  ((state == memc_pkg::wr_data && burst_ready) ||
                   (state == memc_pkg::rd_data && !full_sync));
  assign cmd_code = (state == memc_pkg::rd_data) ? memc_pkg::CMD_READ : memc_pkg::CMD_WRITE;

  // accepted when en and rdy meet
  assign wr_accept = cmd_en && app_rdy && (state == memc_pkg::wr_data);
  assign rd_accept = cmd_en && app_rdy && (state == memc_pkg::rd_data);

  // packer runs until the row pair is done
  assign fill_en = (state == memc_pkg::wr_data) && !wr_track.row_done;

  // ********************
  // frame counter
  // ********************
  // whole images in DDR not yet read back
  always_ff @(posedge clk)
  begin
    if (rst)
      frame_cnt <= '0;
    else
    begin
      case ({wr_track.image_done, rd_track.image_done})
        2'b10: frame_cnt <= frame_cnt + 1'b1;
        2'b01: frame_cnt <= frame_cnt - 1'b1;
        default: frame_cnt <= frame_cnt;
      endcase
    end
  end

endmodule

//--- hdl/memc_pkg.sv
/* widths, command codes, arbiter state and bus structs shared by the DDR front end;
   the RTL refers into it by scoped names */
package memc_pkg;

  // ********************
  // widths
  // ********************
  // controller native port address
  localparam int ADDR_WIDTH = 28;
  // one burst is 64 bytes
  localparam int DATA_BYTES = 64;
  localparam int DATA_WIDTH = DATA_BYTES * 8;
  // byte-wide line buffer, 2k deep
  localparam int BUF_ADDR_WIDTH = 11;
  // images held in DDR and not yet read
  localparam int FRAME_CNT_WIDTH = 12;

  // ********************
  // traffic shape
  // ********************
  // two image lines go out as five bursts
  localparam int CMDS_PER_ROW = 5;
  // address units per burst
  localparam int ADDR_STEP = 8;

  // native port command codes
  localparam logic [2:0] CMD_WRITE = 3'd0;
  localparam logic [2:0] CMD_READ = 3'd1;

  // arbiter states, write has priority
  typedef enum logic [1:0] {
    idle = 2'd0,
    wr_data = 2'd1,
    rd_data = 2'd2
  } memc_state_e;

  // command side of the native port
  typedef struct packed {
    logic en;
    logic [2:0] cmd;
    logic [ADDR_WIDTH-1:0] addr;
  } ddr_cmd_t;

  // write data side, mask tied low outside
  typedef struct packed {
    logic wren;
    logic last;
    logic [DATA_WIDTH-1:0] data;
  } ddr_wdf_t;

  // address tracker report
  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;
    logic row_end;
    logic row_done;
    logic image_done;
  } track_t;

endpackage
